// File: design/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath width
`define EXU_XLEN 32

// alu op codes
`define EXU_ALU_ADD  4'd0
`define EXU_ALU_SUB  4'd1
`define EXU_ALU_AND  4'd2
`define EXU_ALU_OR   4'd3
`define EXU_ALU_XOR  4'd4
`define EXU_ALU_SLT  4'd5
`define EXU_ALU_SLTU 4'd6
`define EXU_ALU_SLL  4'd7
`define EXU_ALU_SRL  4'd8
`define EXU_ALU_SRA  4'd9

// machine csr addresses
`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341
`define EXU_CSR_MCAUSE  12'h342

// csr functions, same as funct3[1:0]
`define EXU_CSRFN_RW 2'd1
`define EXU_CSRFN_RS 2'd2
`define EXU_CSRFN_RC 2'd3

`define EXU_MCAUSE_ECALL 11
`define EXU_MSTATUS_MPIE 7

`endif

// File: design/exu_pkg.sv
`include "exu_consts.svh"

package exu_pkg;

  // meaningful widths
  typedef logic [`EXU_XLEN-1:0] word_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [3:0] alu_op_t;
  typedef logic [1:0] csr_fn_t;

  // decoded instruction from decode
  // csr address rides in imm[11:0]
  typedef struct packed {
    word_t pc;
    word_t src1;
    word_t src2;
    word_t imm;
    word_t jbase;
    reg_idx_t rd;
    alu_op_t alu_op;
    csr_fn_t csr_fn;
    logic is_load;
    logic is_store;
    logic is_jump;
    logic is_branch;
    logic br_invert;
    logic is_csr;
    logic is_ecall;
    logic is_mret;
  } exu_issue_t;

  // one retired item to writeback
  typedef struct packed {
    word_t pc;
    reg_idx_t rd;
    word_t wdata;
    logic redirect;
    word_t npc;
  } exu_result_t;

  // word access on the four-phase memory link
  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic we;
  } mem_req_t;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_REQ,
    MEM_RELEASE
  } mem_state_e;

endpackage

// File: design/exu_alu.sv
`include "exu_consts.svh"

module exu_alu
  import exu_pkg::*;
(
  input  word_t   a_i,
  input  word_t   b_i,
  input  alu_op_t op_i,
  output word_t   res_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      `EXU_ALU_ADD: res_o = a_i + b_i;
      `EXU_ALU_SUB: res_o = a_i - b_i;
      `EXU_ALU_AND: res_o = a_i & b_i;
      `EXU_ALU_OR: res_o = a_i | b_i;
      `EXU_ALU_XOR: res_o = a_i ^ b_i;
      // compare results are a single bit, zero extended
      `EXU_ALU_SLT: begin
        res_o = '0;
        res_o[0] = $signed(a_i) < $signed(b_i);
      end
      `EXU_ALU_SLTU: begin
        res_o = '0;
        res_o[0] = a_i < b_i;
      end
      `EXU_ALU_SLL: res_o = a_i << shamt;
      `EXU_ALU_SRL: res_o = a_i >> shamt;
      `EXU_ALU_SRA: res_o = word_t'($signed(a_i) >>> shamt);
      default: res_o = '0;
    endcase
  end

  // decode only hands over defined op codes, empty stage may still hold x
  assert final ($isunknown(op_i) || (op_i <= `EXU_ALU_SRA))
    else $error("exu_alu: undefined op code %0h", op_i);

endmodule

// File: design/exu_csr_file.sv
`include "exu_consts.svh"

module exu_csr_file
  import exu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  csr_addr_t raddr_i,
  output word_t     rdata_o,
  input  logic      we_i,
  input  csr_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      trap_i,
  input  word_t     trap_pc_i,
  input  logic      mret_i,
  output word_t     mtvec_o,
  output word_t     mepc_o
);

  word_t mstatus_q;
  word_t mtvec_q;
  word_t mepc_q;
  word_t mcause_q;

  // read port, unknown address reads zero
  always_comb begin
    case (raddr_i)
      `EXU_CSR_MSTATUS: rdata_o = mstatus_q;
      `EXU_CSR_MTVEC: rdata_o = mtvec_q;
      `EXU_CSR_MEPC: rdata_o = mepc_q;
      `EXU_CSR_MCAUSE: rdata_o = mcause_q;
      default: rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q <= '0;
      mepc_q <= '0;
      mcause_q <= '0;
    end else begin
      if (we_i) begin
        case (waddr_i)
          `EXU_CSR_MSTATUS: mstatus_q <= wdata_i;
          `EXU_CSR_MTVEC: mtvec_q <= wdata_i;
          `EXU_CSR_MEPC: mepc_q <= wdata_i;
          `EXU_CSR_MCAUSE: mcause_q <= wdata_i;
          default: ;
        endcase
      end
      // ecall is the only trap source
      if (trap_i) begin
        mepc_q <= trap_pc_i;
        mcause_q <= word_t'(`EXU_MCAUSE_ECALL);
      end
      if (mret_i) begin
        mstatus_q[`EXU_MSTATUS_MPIE] <= 1'b1;
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o = mepc_q;

  // one item retires per handoff, so trap and mret never meet
  assert property (@(posedge clk) disable iff (rst) !(trap_i && mret_i))
    else $error("exu_csr_file: trap and mret in the same cycle");

endmodule

// File: design/exu_branch_unit.sv
`include "exu_consts.svh"

module exu_branch_unit
  import exu_pkg::*;
(
  input  exu_issue_t issue_i,
  input  word_t      alu_res_i,
  input  word_t      csr_rdata_i,
  input  word_t      mtvec_i,
  input  word_t      mepc_i,
  output logic       redirect_o,
  output word_t      npc_o,
  output word_t      csr_wdata_o
);

  word_t target;
  logic br_taken;

  assign target = issue_i.jbase + issue_i.imm;

  // compare result from the alu, inverted for beq/bge style encodings
  assign br_taken = (|alu_res_i) ^ issue_i.br_invert;

  assign redirect_o = issue_i.is_jump | issue_i.is_ecall | issue_i.is_mret |
                      (issue_i.is_branch & br_taken);

  always_comb begin
    if (issue_i.is_ecall) begin
      npc_o = mtvec_i;
    end else if (issue_i.is_mret) begin
      npc_o = mepc_i;
    end else if (redirect_o) begin
      npc_o = target;
    end else begin
      npc_o = issue_i.pc + word_t'(4);
    end
  end

  // new csr value from the old one and src1
  always_comb begin
    case (issue_i.csr_fn)
      `EXU_CSRFN_RW: csr_wdata_o = issue_i.src1;
      `EXU_CSRFN_RS: csr_wdata_o = csr_rdata_i | issue_i.src1;
      `EXU_CSRFN_RC: csr_wdata_o = csr_rdata_i & ~issue_i.src1;
      default: csr_wdata_o = csr_rdata_i;
    endcase
  end

endmodule

// File: design/exu_mem_port.sv
module exu_mem_port
  import exu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     start_i,
  input  mem_req_t req_i,
  output logic     done_o,
  output word_t    rdata_o,
  output logic     mem_req_o,
  input  logic     mem_ack_i,
  output mem_req_t mem_o,
  input  word_t    mem_rdata_i
);

  mem_state_e state_q;
  mem_req_t req_q;
  word_t rdata_q;

  // four-phase sequence: req up, ack up, req down, ack down
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= MEM_IDLE;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          if (start_i) begin
            state_q <= MEM_REQ;
          end
        end
        MEM_REQ: begin
          if (mem_ack_i) begin
            state_q <= MEM_RELEASE;
          end
        end
        MEM_RELEASE: begin
          // wait for the slave to drop ack
          if (!mem_ack_i) begin
            state_q <= MEM_IDLE;
          end
        end
        default: state_q <= MEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && (state_q == MEM_IDLE)) begin
      req_q <= req_i;
    end
    // load data valid while ack is high
    if ((state_q == MEM_REQ) && mem_ack_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign mem_req_o = (state_q == MEM_REQ);
  assign mem_o = req_q;
  assign done_o = (state_q == MEM_RELEASE) && !mem_ack_i;
  assign rdata_o = rdata_q;

  // the stage holds off new memory items until done
  assert property (@(posedge clk) disable iff (rst) start_i |-> (state_q == MEM_IDLE))
    else $error("exu_mem_port: start while a transfer is in flight");

endmodule

// File: design/exu_stage.sv
module exu_stage
  import exu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  exu_issue_t  in_issue_i,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output exu_result_t out_result_o,
  output exu_issue_t  issue_o,
  input  word_t       alu_res_i,
  input  word_t       csr_rdata_i,
  input  logic        redirect_i,
  input  word_t       npc_i,
  output logic        csr_we_o,
  output logic        trap_o,
  output logic        mret_o,
  output logic        mem_start_o,
  output mem_req_t    mem_req_o,
  input  logic        mem_done_i,
  input  word_t       mem_rdata_i
);

  exu_issue_t issue_q;
  logic full_q;
  logic mem_busy_q;
  logic accept;
  logic take;
  logic no_wdata;

  // item held and not waiting on memory
  assign out_valid_o = full_q & ~mem_busy_q;
  assign take = out_valid_o & out_ready_i;
  assign in_ready_o = ~full_q | take;
  assign accept = in_valid_i & in_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
      mem_busy_q <= 1'b0;
    end else begin
      if (accept) begin
        full_q <= 1'b1;
        mem_busy_q <= in_issue_i.is_load | in_issue_i.is_store;
      end else begin
        if (take) begin
          full_q <= 1'b0;
        end
        if (mem_done_i) begin
          mem_busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue_q <= in_issue_i;
    end
  end

  // memory access starts with the accept, so req is up one edge later
  assign mem_start_o = accept & (in_issue_i.is_load | in_issue_i.is_store);
  assign mem_req_o.addr = in_issue_i.jbase + in_issue_i.imm;
  assign mem_req_o.wdata = in_issue_i.src2;
  assign mem_req_o.we = in_issue_i.is_store;

  assign issue_o = issue_q;

  assign no_wdata = (issue_q.rd == '0) | issue_q.is_store | issue_q.is_branch;

  always_comb begin
    out_result_o.pc = issue_q.pc;
    out_result_o.rd = issue_q.rd;
    out_result_o.redirect = redirect_i;
    out_result_o.npc = npc_i;
    if (no_wdata) begin
      out_result_o.wdata = '0;
    end else if (issue_q.is_load) begin
      out_result_o.wdata = mem_rdata_i;
    end else if (issue_q.is_csr) begin
      // old value, the write lands at handoff
      out_result_o.wdata = csr_rdata_i;
    end else begin
      out_result_o.wdata = alu_res_i;
    end
  end

  // side effects commit only when writeback takes the item
  assign csr_we_o = take & issue_q.is_csr;
  assign trap_o = take & issue_q.is_ecall;
  assign mret_o = take & issue_q.is_mret;

  assert property (@(posedge clk) disable iff (rst)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_result_o)))
    else $error("exu_stage: result changed under back-pressure");

endmodule

// File: design/exu_top.sv
module exu_top
  import exu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  exu_issue_t  in_issue_i,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output exu_result_t out_result_o,
  output logic        mem_req_o,
  input  logic        mem_ack_i,
  output mem_req_t    mem_o,
  input  word_t       mem_rdata_i
);

  exu_issue_t stage_issue;
  mem_req_t stage_mem_req;
  word_t alu_res;
  word_t csr_rdata;
  word_t csr_wdata;
  word_t csr_mtvec;
  word_t csr_mepc;
  word_t br_npc;
  word_t load_data;
  logic br_redirect;
  logic csr_we;
  logic trap;
  logic mret;
  logic mem_start;
  logic mem_done;

  exu_stage u_stage (
    .clk(clk),
    .rst(rst),
    .in_valid_i(in_valid_i),
    .in_ready_o(in_ready_o),
    .in_issue_i(in_issue_i),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_result_o(out_result_o),
    .issue_o(stage_issue),
    .alu_res_i(alu_res),
    .csr_rdata_i(csr_rdata),
    .redirect_i(br_redirect),
    .npc_i(br_npc),
    .csr_we_o(csr_we),
    .trap_o(trap),
    .mret_o(mret),
    .mem_start_o(mem_start),
    .mem_req_o(stage_mem_req),
    .mem_done_i(mem_done),
    .mem_rdata_i(load_data)
  );

  exu_alu u_alu (
    .a_i(stage_issue.src1),
    .b_i(stage_issue.src2),
    .op_i(stage_issue.alu_op),
    .res_o(alu_res)
  );

  exu_branch_unit u_branch_unit (
    .issue_i(stage_issue),
    .alu_res_i(alu_res),
    .csr_rdata_i(csr_rdata),
    .mtvec_i(csr_mtvec),
    .mepc_i(csr_mepc),
    .redirect_o(br_redirect),
    .npc_o(br_npc),
    .csr_wdata_o(csr_wdata)
  );

  // csr address sits in the immediate
  exu_csr_file u_csr_file (
    .clk(clk),
    .rst(rst),
    .raddr_i(stage_issue.imm[11:0]),
    .rdata_o(csr_rdata),
    .we_i(csr_we),
    .waddr_i(stage_issue.imm[11:0]),
    .wdata_i(csr_wdata),
    .trap_i(trap),
    .trap_pc_i(stage_issue.pc),
    .mret_i(mret),
    .mtvec_o(csr_mtvec),
    .mepc_o(csr_mepc)
  );

  exu_mem_port u_mem_port (
    .clk(clk),
    .rst(rst),
    .start_i(mem_start),
    .req_i(stage_mem_req),
    .done_o(mem_done),
    .rdata_o(load_data),
    .mem_req_o(mem_req_o),
    .mem_ack_i(mem_ack_i),
    .mem_o(mem_o),
    .mem_rdata_i(mem_rdata_i)
  );

endmodule

// File: verification/exu_mem_model.sv
module exu_mem_model
  import exu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] ack_delay_i,
  input  logic       req_i,
  input  mem_req_t   mem_i,
  output logic       ack_o,
  output word_t      rdata_o,
  output logic       proto_err_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 100;

  word_t mem [0:63];
  logic req_q;
  mem_req_t mem_q;
  int wait_cnt;

  initial begin
    ack_o = 1'b0;
    rdata_o = '0;
    proto_err_o = 1'b0;
    req_q = 1'b0;
    mem_q = '0;
  end

  // responder, req sampled mid-cycle
  always begin
    @(negedge clk);
    if (!rst && req_i) begin
      repeat (ack_delay_i) @(posedge clk);
      @(posedge clk);
      #1;
      if (mem_i.we) begin
        mem[mem_i.addr[7:2]] = mem_i.wdata;
      end
      rdata_o = mem[mem_i.addr[7:2]];
      ack_o = 1'b1;
      // wait for the master to release req
      wait_cnt = 0;
      do begin
        @(negedge clk);
        wait_cnt++;
      end while (req_i && wait_cnt < WAIT_LIMIT);
      if (req_i) begin
        proto_err_o = 1'b1;
      end
      repeat (ack_delay_i) @(posedge clk);
      @(posedge clk);
      #1;
      ack_o = 1'b0;
    end
  end

  // four-phase rules seen from the slave side
  always @(negedge clk) begin
    if (!rst) begin
      // new req only once ack is low
      if (req_i && !req_q && ack_o) begin
        proto_err_o = 1'b1;
      end
      // request fields hold while req is up
      if (req_i && req_q && (mem_i !== mem_q)) begin
        proto_err_o = 1'b1;
      end
      // req drops only after ack
      if (!req_i && req_q && !ack_o) begin
        proto_err_o = 1'b1;
      end
    end
    req_q = req_i;
    mem_q = mem_i;
  end

endmodule

// File: verification/exu_tb.sv
`include "exu_consts.svh"

module exu_tb
  import exu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 200;

  logic clk;
  logic rst;
  logic in_valid;
  logic in_ready;
  exu_issue_t in_issue;
  logic out_valid;
  logic out_ready;
  exu_result_t out_result;
  logic mem_req;
  logic mem_ack;
  mem_req_t mem_bus;
  word_t mem_rdata;
  logic [1:0] ack_delay;
  logic proto_err;
  int taken_count = 0;

  // expected machine csr state
  word_t exp_mstatus;
  word_t exp_mtvec;
  word_t exp_mepc;
  word_t exp_mcause;

  exu_top u_exu_top (
    .clk(clk),
    .rst(rst),
    .in_valid_i(in_valid),
    .in_ready_o(in_ready),
    .in_issue_i(in_issue),
    .out_valid_o(out_valid),
    .out_ready_i(out_ready),
    .out_result_o(out_result),
    .mem_req_o(mem_req),
    .mem_ack_i(mem_ack),
    .mem_o(mem_bus),
    .mem_rdata_i(mem_rdata)
  );

  exu_mem_model u_mem_model (
    .clk(clk),
    .rst(rst),
    .ack_delay_i(ack_delay),
    .req_i(mem_req),
    .mem_i(mem_bus),
    .ack_o(mem_ack),
    .rdata_o(mem_rdata),
    .proto_err_o(proto_err)
  );

  always #2 clk = ~clk;

  // results taken by writeback
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      taken_count++;
    end
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("ERR %s expected 0x%08h actual 0x%08h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    stop_run();
  endtask

  function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
    word_t sign_fill;
    // upper bits that an arithmetic right shift copies from the sign
    sign_fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : '0;
    case (op)
      `EXU_ALU_ADD: return a + b;
      `EXU_ALU_SUB: return a - b;
      `EXU_ALU_AND: return a & b;
      `EXU_ALU_OR: return a | b;
      `EXU_ALU_XOR: return a ^ b;
      // signed order is unsigned order with the sign bit flipped
      `EXU_ALU_SLT: return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      `EXU_ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      `EXU_ALU_SLL: return a << b[4:0];
      `EXU_ALU_SRL: return a >> b[4:0];
      `EXU_ALU_SRA: return (a >> b[4:0]) | sign_fill;
      default: return '0;
    endcase
  endfunction

  function automatic word_t csr_expected(input csr_addr_t addr);
    case (addr)
      `EXU_CSR_MSTATUS: return exp_mstatus;
      `EXU_CSR_MTVEC: return exp_mtvec;
      `EXU_CSR_MEPC: return exp_mepc;
      `EXU_CSR_MCAUSE: return exp_mcause;
      default: return '0;
    endcase
  endfunction

  function automatic reg_idx_t rand_rd();
    return reg_idx_t'($urandom_range(31, 1));
  endfunction

  function automatic exu_issue_t new_issue();
    exu_issue_t iss;
    iss = '0;
    iss.pc = $urandom() & 32'hffff_fffc;
    return iss;
  endfunction

  // one item through the stage, stall is the number of cycles out_ready_i stays low
  task automatic run_item(input exu_issue_t iss, input int stall, output exu_result_t res);
    int cnt;
    int count_before;
    int i;
    count_before = taken_count;
    out_ready = (stall == 0);
    in_valid = 1'b1;
    in_issue = iss;
    cnt = 0;
    @(negedge clk);
    while (!in_ready && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!in_ready) begin
      report_timeout("in_ready_o");
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    in_issue = '0;
    cnt = 0;
    @(negedge clk);
    while (!out_valid && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!out_valid) begin
      report_timeout("out_valid_o");
    end
    res = out_result;
    for (i = 0; i < stall; i++) begin
      @(negedge clk);
      check_word("out_valid_o", 32'd1, word_t'(out_valid));
      check_word("in_ready_o", 32'd0, word_t'(in_ready));
      assert (out_result === res) else begin
        $display("ERR out_result_o expected 0x%h actual 0x%h", res, out_result);
        stop_run();
      end
    end
    if (stall > 0) begin
      @(posedge clk);
      #1;
      out_ready = 1'b1;
    end
    @(posedge clk);
    #1;
    // exactly one result per item
    @(negedge clk);
    check_word("out_valid_o", 32'd0, word_t'(out_valid));
    check_word("taken_count", word_t'(count_before + 1), word_t'(taken_count));
    @(posedge clk);
    #1;
  endtask

  task automatic check_result(input exu_issue_t iss, input exu_result_t res,
      input word_t exp_wdata, input logic exp_redirect, input word_t exp_npc);
    check_word("out_result_o.pc", iss.pc, res.pc);
    check_word("out_result_o.rd", word_t'(iss.rd), word_t'(res.rd));
    check_word("out_result_o.wdata", exp_wdata, res.wdata);
    check_word("out_result_o.redirect", word_t'(exp_redirect), word_t'(res.redirect));
    check_word("out_result_o.npc", exp_npc, res.npc);
  endtask

  task automatic mem_access(input logic store, input int idx, input word_t data,
      input int stall, input word_t exp_wdata);
    exu_issue_t iss;
    exu_result_t res;
    iss = new_issue();
    iss.is_store = store;
    iss.is_load = !store;
    iss.rd = rand_rd();
    iss.imm = 32'd8;
    iss.jbase = 32'h0000_1000 + word_t'(idx * 4) - 32'd8;
    iss.src2 = data;
    ack_delay = 2'($urandom_range(3, 0));
    run_item(iss, stall, res);
    check_result(iss, res, exp_wdata, 1'b0, iss.pc + 4);
  endtask

  // csr op, returns the old value and updates the expected state
  task automatic csr_op(input csr_fn_t fn, input csr_addr_t addr, input word_t src);
    exu_issue_t iss;
    exu_result_t res;
    word_t old;
    word_t upd;
    old = csr_expected(addr);
    case (fn)
      `EXU_CSRFN_RW: upd = src;
      `EXU_CSRFN_RS: upd = old | src;
      default: upd = old & ~src;
    endcase
    iss = new_issue();
    iss.is_csr = 1'b1;
    iss.csr_fn = fn;
    iss.imm = {20'h0, addr};
    iss.src1 = src;
    iss.rd = rand_rd();
    run_item(iss, 0, res);
    check_result(iss, res, old, 1'b0, iss.pc + 4);
    case (addr)
      `EXU_CSR_MSTATUS: exp_mstatus = upd;
      `EXU_CSR_MTVEC: exp_mtvec = upd;
      `EXU_CSR_MEPC: exp_mepc = upd;
      `EXU_CSR_MCAUSE: exp_mcause = upd;
      default: ;
    endcase
  endtask

  task automatic test_alu();
    exu_issue_t iss;
    exu_result_t res;
    word_t exp;
    int op;
    int n;
    for (op = 0; op < 10; op++) begin
      for (n = 0; n < 4; n++) begin
        iss = new_issue();
        iss.src1 = $urandom();
        iss.src2 = $urandom();
        iss.alu_op = alu_op_t'(op);
        // last one writes x0
        iss.rd = (n == 3) ? reg_idx_t'(0) : rand_rd();
        exp = (iss.rd == 0) ? '0 : alu_ref(iss.alu_op, iss.src1, iss.src2);
        run_item(iss, 0, res);
        check_result(iss, res, exp, 1'b0, iss.pc + 4);
      end
    end
  endtask

  task automatic test_branch_jump();
    exu_issue_t iss;
    exu_result_t res;
    word_t a;
    word_t b;
    logic taken;
    int k;
    int t;
    for (k = 0; k < 4; k++) begin
      for (t = 0; t < 2; t++) begin
        iss = new_issue();
        iss.is_branch = 1'b1;
        iss.rd = rand_rd();
        iss.jbase = iss.pc;
        iss.imm = ($urandom() & 32'h0000_1ffc) - 32'h0000_1000;
        if (k < 2) begin
          a = $urandom();
          b = (t == 0) ? a : a + 1;
        end else begin
          a = (t == 0) ? 32'hffff_fff0 : 32'h0000_0010;
          b = (t == 0) ? 32'h0000_0010 : 32'hffff_fff0;
        end
        iss.src1 = a;
        iss.src2 = b;
        // beq, bne, blt, bge
        case (k)
          0: begin
            iss.alu_op = `EXU_ALU_SUB;
            iss.br_invert = 1'b1;
            taken = (a == b);
          end
          1: begin
            iss.alu_op = `EXU_ALU_SUB;
            taken = (a != b);
          end
          2: begin
            iss.alu_op = `EXU_ALU_SLT;
            taken = ($signed(a) < $signed(b));
          end
          default: begin
            iss.alu_op = `EXU_ALU_SLT;
            iss.br_invert = 1'b1;
            taken = !($signed(a) < $signed(b));
          end
        endcase
        run_item(iss, 0, res);
        check_result(iss, res, '0, taken, taken ? iss.jbase + iss.imm : iss.pc + 4);
      end
    end
    // jal links pc+4 through the alu
    iss = new_issue();
    iss.is_jump = 1'b1;
    iss.rd = rand_rd();
    iss.jbase = iss.pc;
    iss.imm = ($urandom() & 32'h000f_fffc) - 32'h0008_0000;
    iss.alu_op = `EXU_ALU_ADD;
    iss.src1 = iss.pc;
    iss.src2 = 32'd4;
    run_item(iss, 0, res);
    check_result(iss, res, iss.pc + 4, 1'b1, iss.pc + iss.imm);
  endtask

  task automatic test_mem();
    word_t data [6];
    int idx [6];
    int i;
    for (i = 0; i < 6; i++) begin
      idx[i] = i * 10 + $urandom_range(9, 0);
      data[i] = $urandom();
      mem_access(1'b1, idx[i], data[i], 0, '0);
    end
    for (i = 5; i >= 0; i--) begin
      mem_access(1'b0, idx[i], $urandom(), 0, data[i]);
    end
    assert (!proto_err) else begin
      $display("memory model saw an illegal four-phase sequence");
      stop_run();
    end
  endtask

  task automatic test_csr();
    csr_op(`EXU_CSRFN_RW, `EXU_CSR_MTVEC, $urandom());
    csr_op(`EXU_CSRFN_RS, `EXU_CSR_MTVEC, $urandom());
    csr_op(`EXU_CSRFN_RC, `EXU_CSR_MTVEC, $urandom());
    csr_op(`EXU_CSRFN_RS, `EXU_CSR_MTVEC, '0);
    csr_op(`EXU_CSRFN_RW, `EXU_CSR_MEPC, $urandom());
    csr_op(`EXU_CSRFN_RS, `EXU_CSR_MEPC, $urandom());
    csr_op(`EXU_CSRFN_RC, `EXU_CSR_MEPC, $urandom());
    csr_op(`EXU_CSRFN_RS, `EXU_CSR_MEPC, '0);
    // unimplemented address
    csr_op(`EXU_CSRFN_RW, 12'h7c0, $urandom());
    csr_op(`EXU_CSRFN_RS, 12'h7c0, '0);
  endtask

  task automatic test_trap();
    exu_issue_t iss;
    exu_result_t res;
    csr_op(`EXU_CSRFN_RW, `EXU_CSR_MTVEC, $urandom() & 32'hffff_fffc);
    iss = new_issue();
    iss.is_ecall = 1'b1;
    run_item(iss, 0, res);
    check_result(iss, res, '0, 1'b1, exp_mtvec);
    exp_mepc = iss.pc;
    exp_mcause = `EXU_MCAUSE_ECALL;
    csr_op(`EXU_CSRFN_RS, `EXU_CSR_MEPC, '0);
    csr_op(`EXU_CSRFN_RS, `EXU_CSR_MCAUSE, '0);
    iss = new_issue();
    iss.is_mret = 1'b1;
    run_item(iss, 0, res);
    check_result(iss, res, '0, 1'b1, exp_mepc);
    exp_mstatus[`EXU_MSTATUS_MPIE] = 1'b1;
    csr_op(`EXU_CSRFN_RS, `EXU_CSR_MSTATUS, '0);
  endtask

  task automatic test_backpressure();
    exu_issue_t iss;
    exu_result_t res;
    word_t data;
    int n;
    for (n = 0; n < 3; n++) begin
      iss = new_issue();
      iss.src1 = $urandom();
      iss.src2 = $urandom();
      iss.alu_op = alu_op_t'($urandom_range(9, 0));
      iss.rd = rand_rd();
      run_item(iss, $urandom_range(6, 2), res);
      check_result(iss, res, alu_ref(iss.alu_op, iss.src1, iss.src2), 1'b0, iss.pc + 4);
    end
    data = $urandom();
    mem_access(1'b1, 63, data, 0, '0);
    mem_access(1'b0, 63, '0, $urandom_range(6, 2), data);
  endtask

  initial begin
    void'($urandom(32'heb6bce47));
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_issue = '0;
    out_ready = 1'b1;
    ack_delay = 2'd0;
    exp_mstatus = '0;
    exp_mtvec = '0;
    exp_mepc = '0;
    exp_mcause = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_word("in_ready_o", 32'd1, word_t'(in_ready));
    check_word("out_valid_o", 32'd0, word_t'(out_valid));
    check_word("mem_req_o", 32'd0, word_t'(mem_req));
    @(posedge clk);
    #1;
    test_alu();
    test_branch_jump();
    test_mem();
    test_csr();
    test_trap();
    test_backpressure();
    if (proto_err) begin
      $display("memory model saw an illegal four-phase sequence");
      $display("Test failed");
      $fatal(1, "simulation stopped on a protocol error");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// File: tb.f
+incdir+design
design/exu_pkg.sv
design/exu_alu.sv
design/exu_csr_file.sv
design/exu_branch_unit.sv
design/exu_mem_port.sv
design/exu_stage.sv
design/exu_top.sv
verification/exu_mem_model.sv
verification/exu_tb.sv
